/* rtl/dvi_pkg.sv */
package dvi_pkg;

    // one color component and one encoded symbol
    typedef logic [7:0] pixel_t;
    typedef logic [9:0] symbol_t;

    // pixel or line counter, wide enough for 2047
    typedef logic [10:0] coord_t;

    // lane 0 blue, lane 1 green, lane 2 red (DVI channel order)
    localparam int NUM_LANES = 3;

    typedef struct packed {
        pixel_t red;
        pixel_t green;
        pixel_t blue;
    } rgb_t;

    // timing strobes, all active high
    typedef struct packed {
        logic de;
        logic hsync;
        logic vsync;
        logic frame_start;
    } video_ctrl_t;

    // encoder input, ctrl is {c1, c0}
    typedef struct packed {
        logic       de;
        logic [1:0] ctrl;
        pixel_t     data;
    } tmds_lane_t;

    typedef struct packed {
        symbol_t blue;
        symbol_t green;
        symbol_t red;
    } tmds_bus_t;

    // DVI control tokens, indexed by {c1, c0}
    localparam symbol_t CTRL_TOKEN_00 = 10'b1101010100;
    localparam symbol_t CTRL_TOKEN_01 = 10'b0010101011;
    localparam symbol_t CTRL_TOKEN_10 = 10'b0101010100;
    localparam symbol_t CTRL_TOKEN_11 = 10'b1010101011;

    // 640x480 at 60 Hz
    localparam int DEF_H_ACTIVE = 640;
    localparam int DEF_H_FRONT  = 16;
    localparam int DEF_H_SYNC   = 96;
    localparam int DEF_H_BACK   = 48;
    localparam int DEF_V_ACTIVE = 480;
    localparam int DEF_V_FRONT  = 10;
    localparam int DEF_V_SYNC   = 2;
    localparam int DEF_V_BACK   = 33;

endpackage

/* rtl/video_timing_gen.sv */
`timescale 1ns/1ns

module video_timing_gen #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                 clk_pixel,
    input  logic                 rst_n_i,
    output dvi_pkg::video_ctrl_t ctrl_o
);

    import dvi_pkg::*;

    // line and frame totals
    localparam coord_t H_TOTAL = coord_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK);
    localparam coord_t V_TOTAL = coord_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK);

    // sync windows with start inclusive and end exclusive
    localparam coord_t H_ACT_END  = coord_t'(H_ACTIVE);
    localparam coord_t H_SYNC_BEG = coord_t'(H_ACTIVE + H_FRONT);
    localparam coord_t H_SYNC_END = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam coord_t V_ACT_END  = coord_t'(V_ACTIVE);
    localparam coord_t V_SYNC_BEG = coord_t'(V_ACTIVE + V_FRONT);
    localparam coord_t V_SYNC_END = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

    coord_t      h_cnt;
    coord_t      v_cnt;
    logic        h_last;
    logic        v_last;
    video_ctrl_t ctrl_d;

    assign h_last = (h_cnt == H_TOTAL - coord_t'(1));
    assign v_last = (v_cnt == V_TOTAL - coord_t'(1));

    // pixel counter wraps at line total
    always_ff @(posedge clk_pixel or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + coord_t'(1);
        end
    end

    // line counter steps on each line wrap
    always_ff @(posedge clk_pixel or negedge rst_n_i) begin
        if (!rst_n_i) begin
            v_cnt <= '0;
        end else if (h_last) begin
            if (v_last) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + coord_t'(1);
            end
        end
    end

    // decode strobes from current counter state
    always_comb begin
        ctrl_d.de          = (h_cnt < H_ACT_END) && (v_cnt < V_ACT_END);
        ctrl_d.hsync       = (h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END);
        // vsync covers whole lines
        ctrl_d.vsync       = (v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_END);
        ctrl_d.frame_start = (h_cnt == '0) && (v_cnt == '0);
    end

    // registered outputs one cycle behind the counters
    always_ff @(posedge clk_pixel or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_o <= '0;
        end else begin
            ctrl_o <= ctrl_d;
        end
    end

    // counters never leave the frame
    a_cnt_range: assert property (
        @(posedge clk_pixel) disable iff (!rst_n_i)
        (h_cnt < H_TOTAL) && (v_cnt < V_TOTAL)
    ) else $error("timing counter out of range h=%0d v=%0d", h_cnt, v_cnt);

endmodule

/* rtl/pixel_source.sv */
`timescale 1ns/1ns

module pixel_source (
    input  logic                 clk_pixel,
    input  logic                 rst_n_i,
    input  dvi_pkg::video_ctrl_t ctrl_i,
    input  dvi_pkg::rgb_t        fill_color_i,
    output dvi_pkg::tmds_lane_t  lanes_o [dvi_pkg::NUM_LANES]
);

    import dvi_pkg::*;

    rgb_t   color_q;
    rgb_t   color_cur;
    pixel_t comp [NUM_LANES];

    // new color takes effect on the frame start pixel itself
    assign color_cur = ctrl_i.frame_start ? fill_color_i : color_q;

    // per-lane component, DVI channel order
    always_comb begin
        comp[0] = color_cur.blue;
        comp[1] = color_cur.green;
        comp[2] = color_cur.red;
    end

    // hold color for the rest of the frame
    always_ff @(posedge clk_pixel or negedge rst_n_i) begin
        if (!rst_n_i) begin
            color_q <= '0;
        end else if (ctrl_i.frame_start) begin
            color_q <= fill_color_i;
        end
    end

    always_ff @(posedge clk_pixel or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                lanes_o[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                lanes_o[i].de   <= ctrl_i.de;
                // data zeroed in blanking
                lanes_o[i].data <= ctrl_i.de ? comp[i] : '0;
                // syncs ride on blue only
                lanes_o[i].ctrl <= (i == 0) ? {ctrl_i.vsync, ctrl_i.hsync} : 2'b00;
            end
        end
    end

    // color register moves only at frame start
    a_color_per_frame: assert property (
        @(posedge clk_pixel) disable iff (!rst_n_i)
        $changed(color_q) |-> $past(ctrl_i.frame_start)
    ) else $error("fill color changed mid-frame");

endmodule

/* rtl/tmds_channel_encoder.sv */
`timescale 1ns/1ns

module tmds_channel_encoder (
    input  logic                clk_pixel,
    input  logic                rst_n_i,
    input  dvi_pkg::tmds_lane_t lane_i,
    output dvi_pkg::symbol_t    symbol_o
);

    import dvi_pkg::*;

    // ones count of a byte
    function automatic logic [3:0] count_ones(input logic [7:0] v);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 8; i++) begin
            n = n + {3'b000, v[i]};
        end
        return n;
    endfunction

    logic [3:0]        n1_d;
    logic              use_xnor;
    logic [8:0]        q_m;
    logic [3:0]        n1_q;
    logic signed [5:0] diff_q;
    logic signed [5:0] cnt_q;
    logic signed [5:0] cnt_d;
    symbol_t           sym_d;

    // stage 1 does transition minimization
    always_comb begin
        n1_d     = count_ones(lane_i.data);
        use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !lane_i.data[0]);
        q_m[0]   = lane_i.data[0];
        for (int i = 1; i < 8; i++) begin
            if (use_xnor) begin
                q_m[i] = ~(q_m[i-1] ^ lane_i.data[i]);
            end else begin
                q_m[i] = q_m[i-1] ^ lane_i.data[i];
            end
        end
        // bit 8 flags xor
        q_m[8] = ~use_xnor;
    end

    // ones minus zeros of q_m[7:0] in -8..8
    assign n1_q   = count_ones(q_m[7:0]);
    assign diff_q = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;

    // stage 2 picks dc balance or control token
    always_comb begin
        sym_d = CTRL_TOKEN_00;
        cnt_d = cnt_q;
        if (!lane_i.de) begin
            // blanking resets the running disparity
            cnt_d = '0;
            case (lane_i.ctrl)
                2'b00:   sym_d = CTRL_TOKEN_00;
                2'b01:   sym_d = CTRL_TOKEN_01;
                2'b10:   sym_d = CTRL_TOKEN_10;
                default: sym_d = CTRL_TOKEN_11;
            endcase
        end else if ((cnt_q == 6'sd0) || (diff_q == 6'sd0)) begin
            // no bias either way so invert follows bit 8
            sym_d = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            if (q_m[8]) begin
                cnt_d = cnt_q + diff_q;
            end else begin
                cnt_d = cnt_q - diff_q;
            end
        end else if (((cnt_q > 6'sd0) && (diff_q > 6'sd0)) ||
                     ((cnt_q < 6'sd0) && (diff_q < 6'sd0))) begin
            // would grow the bias, so invert
            sym_d = {1'b1, q_m[8], ~q_m[7:0]};
            cnt_d = cnt_q + (q_m[8] ? 6'sd2 : 6'sd0) - diff_q;
        end else begin
            sym_d = {1'b0, q_m[8], q_m[7:0]};
            cnt_d = cnt_q - (q_m[8] ? 6'sd0 : 6'sd2) + diff_q;
        end
    end

    // symbol register shows token 00 out of reset
    always_ff @(posedge clk_pixel or negedge rst_n_i) begin
        if (!rst_n_i) begin
            symbol_o <= CTRL_TOKEN_00;
            cnt_q    <= '0;
        end else begin
            symbol_o <= sym_d;
            cnt_q    <= cnt_d;
        end
    end

    // running disparity bounded
    a_disparity_range: assert property (
        @(posedge clk_pixel) disable iff (!rst_n_i)
        (cnt_q >= -6'sd16) && (cnt_q <= 6'sd16)
    ) else $error("running disparity out of range: %0d", cnt_q);

endmodule

/* rtl/dvi_tx_top.sv */
`timescale 1ns/1ns

module dvi_tx_top #(
    parameter int H_ACTIVE = dvi_pkg::DEF_H_ACTIVE,
    parameter int H_FRONT  = dvi_pkg::DEF_H_FRONT,
    parameter int H_SYNC   = dvi_pkg::DEF_H_SYNC,
    parameter int H_BACK   = dvi_pkg::DEF_H_BACK,
    parameter int V_ACTIVE = dvi_pkg::DEF_V_ACTIVE,
    parameter int V_FRONT  = dvi_pkg::DEF_V_FRONT,
    parameter int V_SYNC   = dvi_pkg::DEF_V_SYNC,
    parameter int V_BACK   = dvi_pkg::DEF_V_BACK
) (
    input  logic               clk_pixel,
    input  logic               rst_n_i,
    input  dvi_pkg::rgb_t      fill_color_i,
    output dvi_pkg::tmds_bus_t tmds_o
);

    import dvi_pkg::*;

    localparam int SYM_W = $bits(symbol_t);

    video_ctrl_t ctrl;
    tmds_lane_t  lanes [NUM_LANES];

    // counters and sync decode
    video_timing_gen #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) u_timing (
        .clk_pixel (clk_pixel),
        .rst_n_i   (rst_n_i),
        .ctrl_o    (ctrl)
    );

    pixel_source u_source (
        .clk_pixel    (clk_pixel),
        .rst_n_i      (rst_n_i),
        .ctrl_i       (ctrl),
        .fill_color_i (fill_color_i),
        .lanes_o      (lanes)
    );

    // lane 0 blue lands in the top slice of the bus
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        tmds_channel_encoder u_enc (
            .clk_pixel (clk_pixel),
            .rst_n_i   (rst_n_i),
            .lane_i    (lanes[i]),
            .symbol_o  (tmds_o[(NUM_LANES - i) * SYM_W - 1 -: SYM_W])
        );
    end

endmodule

/* sim/tb_dvi_tx_top.sv */
`timescale 1ns/1ns

module tb_dvi_tx_top;

    import dvi_pkg::*;

    // small test mode of 24 cycles per line and 12 lines per frame
    localparam int H_ACT = 16;
    localparam int H_FP  = 2;
    localparam int H_SW  = 3;
    localparam int H_BP  = 3;
    localparam int V_ACT = 8;
    localparam int V_FP  = 1;
    localparam int V_SW  = 2;
    localparam int V_BP  = 1;
    localparam int H_TOT = H_ACT + H_FP + H_SW + H_BP;
    localparam int V_TOT = V_ACT + V_FP + V_SW + V_BP;
    // control run from the last data line to the next frame
    localparam int FRAME_GAP  = (H_TOT - H_ACT) + (V_TOT - V_ACT) * H_TOT;
    localparam int NUM_FRAMES = 8;
    localparam int MAX_CYCLES = 2500;
    localparam int HIST_LEN   = 300;

    logic      clk_pixel;
    logic      rst_n;
    rgb_t      fill_color;
    tmds_bus_t tmds;

    integer seed = 32'h3622;
    int     errors;
    int     cyc;
    int     post_rst;
    int     frames_done;

    // decoded view of the current symbols
    symbol_t    sym [NUM_LANES];
    logic       is_ctrl [NUM_LANES];
    pixel_t     dec [NUM_LANES];
    rgb_t       dec_rgb;
    logic [1:0] pair_now;
    logic       is_data;
    logic       data_start;
    logic       frame_start_seen;
    logic       hs_now;
    logic       vs_now;
    logic       exp_de;
    logic       exp_hs;
    logic       exp_vs;
    int         exp_gap;
    int         phase_now;
    int         line_now;

    // history of earlier symbols
    logic prev_data;
    logic synced;
    logic color_ok;
    int   run_len;
    int   blank_len;
    int   phase_q;
    int   line_q;
    int   lines_q;
    rgb_t frame_val;
    int   tally_q [NUM_LANES];
    rgb_t hist [HIST_LEN];

    dvi_tx_top #(
        .H_ACTIVE (H_ACT),
        .H_FRONT  (H_FP),
        .H_SYNC   (H_SW),
        .H_BACK   (H_BP),
        .V_ACTIVE (V_ACT),
        .V_FRONT  (V_FP),
        .V_SYNC   (V_SW),
        .V_BACK   (V_BP)
    ) dut (
        .clk_pixel    (clk_pixel),
        .rst_n_i      (rst_n),
        .fill_color_i (fill_color),
        .tmds_o       (tmds)
    );

    function automatic logic token_match(input symbol_t s);
        return (s == CTRL_TOKEN_00) || (s == CTRL_TOKEN_01) ||
               (s == CTRL_TOKEN_10) || (s == CTRL_TOKEN_11);
    endfunction

    // {c1, c0} carried by a token
    function automatic logic [1:0] token_pair(input symbol_t s);
        case (s)
            CTRL_TOKEN_01: return 2'b01;
            CTRL_TOKEN_10: return 2'b10;
            CTRL_TOKEN_11: return 2'b11;
            default:       return 2'b00;
        endcase
    endfunction

    // bit 9 undoes inversion and bit 8 picks xor or xnor chain
    function automatic pixel_t decode_symbol(input symbol_t s);
        logic [7:0] q;
        pixel_t     b;
        q    = s[9] ? ~s[7:0] : s[7:0];
        b[0] = q[0];
        for (int i = 1; i < 8; i++) begin
            b[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        end
        return b;
    endfunction

    // ones minus zeros over all ten bits
    function automatic int symbol_disparity(input symbol_t s);
        int n;
        n = 0;
        for (int i = 0; i < 10; i++) begin
            n = n + int'(s[i]);
        end
        return 2 * n - 10;
    endfunction

    function automatic pixel_t lane_field(input rgb_t c, input int l);
        if (l == 0) begin
            return c.blue;
        end else if (l == 1) begin
            return c.green;
        end
        return c.red;
    endfunction

    function automatic logic color_in_history(input rgb_t c);
        for (int i = 0; i < HIST_LEN; i++) begin
            if (hist[i] == c) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    assign sym[0] = tmds.blue;
    assign sym[1] = tmds.green;
    assign sym[2] = tmds.red;

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            is_ctrl[l] = token_match(sym[l]);
            dec[l]     = decode_symbol(sym[l]);
        end
        dec_rgb          = {dec[2], dec[1], dec[0]};
        pair_now         = token_pair(sym[0]);
        hs_now           = pair_now[0];
        vs_now           = pair_now[1];
        is_data          = !is_ctrl[0];
        data_start       = is_data && !prev_data;
        // a data run after the last active line opens a frame
        frame_start_seen = data_start && (!synced || (line_q >= V_ACT - 1));
        exp_gap          = (line_q < V_ACT - 1) ? (H_TOT - H_ACT) : FRAME_GAP;
        // position in the line locked to the first data symbol
        if (data_start || (phase_q == H_TOT - 1)) begin
            phase_now = 0;
        end else begin
            phase_now = phase_q + 1;
        end
        if (frame_start_seen) begin
            line_now = 0;
        end else if (phase_now == 0) begin
            line_now = line_q + 1;
        end else begin
            line_now = line_q;
        end
        exp_de = (line_now < V_ACT) && (phase_now < H_ACT);
        exp_hs = (phase_now >= H_ACT + H_FP) && (phase_now < H_ACT + H_FP + H_SW);
        exp_vs = (line_now >= V_ACT + V_FP) && (line_now < V_ACT + V_FP + V_SW);
    end

    always @(posedge clk_pixel) begin
        cyc                 <= cyc + 1;
        hist[cyc % HIST_LEN] <= fill_color;
        if (!rst_n) begin
            post_rst  <= 0;
            prev_data <= 1'b0;
            synced    <= 1'b0;
            color_ok  <= 1'b1;
            run_len   <= 0;
            blank_len <= 0;
            phase_q   <= 0;
            line_q    <= 0;
            lines_q   <= 0;
            frame_val <= '0;
            for (int l = 0; l < NUM_LANES; l++) begin
                tally_q[l] <= 0;
            end
        end else begin
            post_rst  <= post_rst + 1;
            prev_data <= is_data;
            run_len   <= is_data ? run_len + 1 : 0;
            blank_len <= is_data ? 0 : blank_len + 1;
            phase_q   <= phase_now;
            line_q    <= line_now;
            if (!is_data && (run_len != 0)) begin
                lines_q <= lines_q + 1;
            end
            if (frame_start_seen) begin
                synced    <= 1'b1;
                lines_q   <= 0;
                frame_val <= dec_rgb;
                color_ok  <= color_in_history(dec_rgb);
                if (synced) begin
                    frames_done <= frames_done + 1;
                end
            end
            // running tally cleared by any control symbol
            for (int l = 0; l < NUM_LANES; l++) begin
                tally_q[l] <= is_ctrl[l] ? 0 : tally_q[l] + symbol_disparity(sym[l]);
            end
        end
    end

    a_reset_tokens: assert property (@(posedge clk_pixel)
        (cyc > 0) && (!rst_n || (post_rst < 3)) |->
            (tmds == {CTRL_TOKEN_00, CTRL_TOKEN_00, CTRL_TOKEN_00})
    ) else begin
        errors++;
        $display("ERR reset_tokens: expected %h actual %h",
                 {CTRL_TOKEN_00, CTRL_TOKEN_00, CTRL_TOKEN_00}, $sampled(tmds));
    end

    a_data_run: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        !is_data && (run_len != 0) |-> (run_len == H_ACT)
    ) else begin
        errors++;
        $display("ERR data_run: expected %0d actual %0d", H_ACT, $sampled(run_len));
    end

    a_blank_gap: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        synced && data_start |-> (blank_len == exp_gap)
    ) else begin
        errors++;
        $display("ERR blank_gap: expected %0d actual %0d",
                 $sampled(exp_gap), $sampled(blank_len));
    end

    a_frame_lines: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        synced && frame_start_seen |-> (lines_q == V_ACT)
    ) else begin
        errors++;
        $display("ERR frame_lines: expected %0d actual %0d", V_ACT, $sampled(lines_q));
    end

    a_de_window: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        synced |-> (is_data == exp_de)
    ) else begin
        errors++;
        $display("ERR de_window: expected %0b actual %0b (line %0d phase %0d)",
                 $sampled(exp_de), $sampled(is_data),
                 $sampled(line_now), $sampled(phase_now));
    end

    a_hsync: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        synced && !is_data |-> (hs_now == exp_hs)
    ) else begin
        errors++;
        $display("ERR hsync: expected %0b actual %0b (phase %0d)",
                 $sampled(exp_hs), $sampled(hs_now), $sampled(phase_now));
    end

    a_vsync: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        synced && !is_data |-> (vs_now == exp_vs)
    ) else begin
        errors++;
        $display("ERR vsync: expected %0b actual %0b (line %0d)",
                 $sampled(exp_vs), $sampled(vs_now), $sampled(line_now));
    end

    a_color_recent: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        frame_start_seen |=> color_ok
    ) else begin
        errors++;
        $display("frame color %h was not driven in the last %0d cycles",
                 $sampled(frame_val), HIST_LEN);
    end

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane_chk
        // green and red follow the blue blanking and never carry syncs
        if (l > 0) begin : g_quiet
            a_lane_align: assert property (@(posedge clk_pixel) disable iff (!rst_n)
                is_ctrl[l] == is_ctrl[0]
            ) else begin
                errors++;
                $display("ERR lane_align_%0d: expected %0b actual %0b",
                         l, $sampled(is_ctrl[0]), $sampled(is_ctrl[l]));
            end

            a_quiet_blank: assert property (@(posedge clk_pixel) disable iff (!rst_n)
                is_ctrl[0] |-> (sym[l] == CTRL_TOKEN_00)
            ) else begin
                errors++;
                $display("ERR quiet_blank_%0d: expected %b actual %b",
                         l, CTRL_TOKEN_00, $sampled(sym[l]));
            end
        end

        a_frame_color: assert property (@(posedge clk_pixel) disable iff (!rst_n)
            synced && is_data && !frame_start_seen |-> (dec[l] == lane_field(frame_val, l))
        ) else begin
            errors++;
            $display("ERR frame_color_%0d: expected %h actual %h",
                     l, lane_field($sampled(frame_val), l), $sampled(dec[l]));
        end

        a_dc_balance: assert property (@(posedge clk_pixel) disable iff (!rst_n)
            (tally_q[l] >= -16) && (tally_q[l] <= 16)
        ) else begin
            errors++;
            $display("ERR dc_balance_%0d: expected within 16 actual %0d",
                     l, $sampled(tally_q[l]));
        end
    end

    initial begin
        clk_pixel = 1'b0;
        forever #2 clk_pixel = ~clk_pixel;
    end

    // new fill color every 20 to 219 cycles
    initial begin
        int gap;
        @(posedge rst_n);
        forever begin
            gap = 20 + int'($unsigned($random(seed)) % 200);
            repeat (gap) @(posedge clk_pixel);
            fill_color <= rgb_t'($random(seed));
        end
    end

    initial begin
        rst_n      <= 1'b0;
        fill_color <= '0;
        repeat (10) @(posedge clk_pixel);
        rst_n <= 1'b1;
        while ((frames_done < NUM_FRAMES) && (cyc < MAX_CYCLES)) begin
            @(posedge clk_pixel);
        end
        if (frames_done < NUM_FRAMES) begin
            errors++;
            $display("timeout after %0d cycles, only %0d of %0d frames seen",
                     cyc, frames_done, NUM_FRAMES);
        end
        $display("errors: %0d, frames checked: %0d, cycles: %0d", errors, frames_done, cyc);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* compile.f */
rtl/dvi_pkg.sv
rtl/video_timing_gen.sv
rtl/pixel_source.sv
rtl/tmds_channel_encoder.sv
rtl/dvi_tx_top.sv
sim/tb_dvi_tx_top.sv

/* Bender.yml */
package:
  name: dvi_tx

sources:
  # package first, then the blocks it feeds
  - rtl/dvi_pkg.sv
  - rtl/video_timing_gen.sv
  - rtl/pixel_source.sv
  - rtl/tmds_channel_encoder.sv
  - rtl/dvi_tx_top.sv

  - target: simulation
    files:
      - sim/tb_dvi_tx_top.sv

# sim top: tb_dvi_tx_top
# rtl top: dvi_tx_top
# file list: compile.f
